/* src/axi2ahbConsts.svh */
`ifndef AXI2AHB_CONSTS_SVH
`define AXI2AHB_CONSTS_SVH

////////////////////
// Bus widths
////////////////////
`define AXI2AHB_DATA_W 32
`define AXI2AHB_ADDR_W 32
`define AXI2AHB_ID_W 4

// AXI3 burst length field, beats minus one
`define AXI2AHB_LEN_W 4

// Entries in each burst buffer
`define AXI2AHB_DEPTH 16

////////////////////
// Encodings
////////////////////
`define AXI2AHB_RESP_OKAY 2'd0
`define AXI2AHB_RESP_SLVERR 2'd2

`define AXI2AHB_HTRANS_IDLE 2'd0
`define AXI2AHB_HTRANS_NONSEQ 2'd2

`endif

/* src/axi2ahbPkg.sv */
`default_nettype none

`include "axi2ahbConsts.svh"

package axi2ahbPkg;

    ////////////////////
    // Bus fields
    ////////////////////

    // One full word on either bus
    typedef logic [`AXI2AHB_DATA_W-1:0] dataT;

    typedef logic [`AXI2AHB_ADDR_W-1:0] addrT;

    // Transaction ID, returned on B and R
    typedef logic [`AXI2AHB_ID_W-1:0] idT;

    // Beats minus one, as in AWLEN and ARLEN
    typedef logic [`AXI2AHB_LEN_W-1:0] lenT;

    ////////////////////
    // Buffers
    ////////////////////

    // Index into a sixteen-entry burst buffer
    typedef logic [$clog2(`AXI2AHB_DEPTH)-1:0] bufIdxT;

    // Read buffer entry, word plus the HRESP seen with it
    typedef struct packed {
        logic err;
        dataT data;
    } rdEntryT;

endpackage

`default_nettype wire

/* src/bridgeReqIf.sv */
`timescale 1ns/1ps
`default_nettype none

// Pending transaction from the AXI side and its completion from the AHB side
interface bridgeReqIf;

    // Held from the end of address or data collection until done
    logic             pend;
    logic             isWrite;
    axi2ahbPkg::addrT addr;
    axi2ahbPkg::lenT  len;

    // One-cycle completion pulse, err qualified by it
    logic             done;
    logic             err;

    modport request (
        output pend,
        output isWrite,
        output addr,
        output len,
        input  done,
        input  err
    );

    modport service (
        input  pend,
        input  isWrite,
        input  addr,
        input  len,
        output done,
        output err
    );

endinterface

`default_nettype wire

/* src/burstBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi2ahbConsts.svh"

// Small burst store, written on the clock edge and read combinationally
module burstBuffer #(
    parameter type payloadT = axi2ahbPkg::dataT
) (
    input  wire logic               clk,
    input  wire logic               we,
    input  wire axi2ahbPkg::bufIdxT wrIdx,
    input  wire payloadT            wrData,
    input  wire axi2ahbPkg::bufIdxT rdIdx,
    output payloadT                 rdData
);

    payloadT mem [`AXI2AHB_DEPTH];

    ////////////////////
    // Write port
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[wrIdx] <= wrData;
        end
    end

    ////////////////////
    // Read port
    ////////////////////

    // Same-cycle read, the consumer steers rdIdx
    assign rdData = mem[rdIdx];

endmodule

`default_nettype wire

/* src/axiSlaveCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi2ahbConsts.svh"

// AXI3 slave side: address and data capture, buffer access, B and R responses
module axiSlaveCtrl (
    input  wire logic                ACLK,
    input  wire logic                arstN,
    bridgeReqIf.request              link,

    // Write address, data and response
    input  wire logic                awValid,
    input  wire axi2ahbPkg::addrT    awAddr,
    input  wire axi2ahbPkg::lenT     awLen,
    input  wire axi2ahbPkg::idT      awId,
    input  wire logic                wValid,
    input  wire axi2ahbPkg::dataT    wData,
    input  wire logic                wLast,
    input  wire logic                bReady,

    // Read address and data
    input  wire logic                arValid,
    input  wire axi2ahbPkg::addrT    arAddr,
    input  wire axi2ahbPkg::lenT     arLen,
    input  wire axi2ahbPkg::idT      arId,
    input  wire logic                rReady,

    input  wire axi2ahbPkg::rdEntryT rdBufEntry,

    output logic                     awReady,
    output logic                     wReady,
    output logic                     bValid,
    output logic [1:0]               bResp,
    output axi2ahbPkg::idT           bId,
    output logic                     arReady,
    output logic                     rValid,
    output axi2ahbPkg::dataT         rData,
    output logic [1:0]               rResp,
    output axi2ahbPkg::idT           rId,
    output logic                     rLast,

    // Buffer ports
    output logic                     wrBufWe,
    output axi2ahbPkg::bufIdxT       wrBufIdx,
    output axi2ahbPkg::dataT         wrBufData,
    output axi2ahbPkg::bufIdxT       rdBufIdx
);

    typedef enum logic [2:0] {
        IDLE,
        WDATA,
        BUSY,
        BRESP,
        RDATA
    } stateT;

    stateT              state;
    logic               addrRdy;
    axi2ahbPkg::idT     id;
    axi2ahbPkg::bufIdxT beatCnt;

    logic               awHs;
    logic               arHs;
    logic               wHs;

    ////////////////////
    // Handshakes
    ////////////////////

    // Write wins when both address channels are valid together
    assign awReady = addrRdy;
    assign arReady = addrRdy && !awValid;

    assign awHs = awValid && awReady;
    assign arHs = arValid && arReady;
    assign wHs  = wValid && wReady;

    ////////////////////
    // Buffer access
    ////////////////////
    assign wrBufWe   = wHs;
    assign wrBufIdx  = beatCnt;
    assign wrBufData = wData;

    // Index only moves on an accepted beat, so R payload holds under backpressure
    assign rdBufIdx = beatCnt;
    assign rData    = rdBufEntry.data;
    assign rResp    = rdBufEntry.err ? `AXI2AHB_RESP_SLVERR : `AXI2AHB_RESP_OKAY;
    assign rLast    = (beatCnt == link.len);

    assign rId = id;
    assign bId = id;

    ////////////////////
    // Control FSM
    ////////////////////
    always_ff @(posedge ACLK or negedge arstN)
    begin
        if (!arstN)
        begin
            state     <= IDLE;
            addrRdy   <= 1'b0;
            wReady    <= 1'b0;
            bValid    <= 1'b0;
            rValid    <= 1'b0;
            link.pend <= 1'b0;
            beatCnt   <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    beatCnt <= '0;
                    if (awHs)
                    begin
                        addrRdy <= 1'b0;
                        wReady  <= 1'b1;
                        state   <= WDATA;
                    end
                    else if (arHs)
                    begin
                        // Nothing to collect for a read
                        addrRdy   <= 1'b0;
                        link.pend <= 1'b1;
                        state     <= BUSY;
                    end
                    else
                    begin
                        addrRdy <= 1'b1;
                    end
                end

                WDATA:
                begin
                    if (wHs)
                    begin
                        beatCnt <= beatCnt + 1'b1;
                        if (wLast)
                        begin
                            wReady    <= 1'b0;
                            link.pend <= 1'b1;
                            state     <= BUSY;
                        end
                    end
                end

                BUSY:
                begin
                    if (link.done)
                    begin
                        link.pend <= 1'b0;
                        beatCnt   <= '0;
                        if (link.isWrite)
                        begin
                            bValid <= 1'b1;
                            state  <= BRESP;
                        end
                        else
                        begin
                            rValid <= 1'b1;
                            state  <= RDATA;
                        end
                    end
                end

                BRESP:
                begin
                    if (bReady)
                    begin
                        bValid  <= 1'b0;
                        addrRdy <= 1'b1;
                        state   <= IDLE;
                    end
                end

                RDATA:
                begin
                    if (rReady)
                    begin
                        if (rLast)
                        begin
                            rValid  <= 1'b0;
                            addrRdy <= 1'b1;
                            state   <= IDLE;
                        end
                        else
                        begin
                            beatCnt <= beatCnt + 1'b1;
                        end
                    end
                end

                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Request payload
    ////////////////////
    always_ff @(posedge ACLK)
    begin
        if (awHs)
        begin
            link.isWrite <= 1'b1;
            link.addr    <= awAddr;
            link.len     <= awLen;
            id           <= awId;
        end
        else if (arHs)
        begin
            link.isWrite <= 1'b0;
            link.addr    <= arAddr;
            link.len     <= arLen;
            id           <= arId;
        end

        // Any erred AHB beat turns the single B response into SLVERR
        if (state == BUSY && link.done)
        begin
            bResp <= link.err ? `AXI2AHB_RESP_SLVERR : `AXI2AHB_RESP_OKAY;
        end
    end

    // R beat must not move or vanish before the master takes it
    rHoldChk: assert property (@(posedge ACLK) disable iff (!arstN)
        rValid && !rReady |=> rValid && $stable(rData));

endmodule

`default_nettype wire

/* src/ahbMasterCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi2ahbConsts.svh"

// AHB-Lite master side replaying one pending transaction as pipelined single beats
module ahbMasterCtrl (
    input  wire logic               ACLK,
    input  wire logic               arstN,
    bridgeReqIf.service             link,

    input  wire logic               hReady,
    input  wire logic               hResp,
    input  wire axi2ahbPkg::dataT   hRdata,
    input  wire axi2ahbPkg::dataT   wrBufData,

    output axi2ahbPkg::addrT        hAddr,
    output logic                    hWrite,
    output logic [1:0]              hTrans,
    output logic [2:0]              hSize,
    output logic [2:0]              hBurst,
    output axi2ahbPkg::dataT        hWdata,

    output axi2ahbPkg::bufIdxT      wrBufIdx,
    output logic                    rdBufWe,
    output axi2ahbPkg::bufIdxT      rdBufIdx,
    output axi2ahbPkg::rdEntryT     rdBufEntry
);

    logic               busy;
    logic               aPhase;
    logic               dPhase;
    logic               errAcc;
    axi2ahbPkg::bufIdxT aIdx;
    axi2ahbPkg::bufIdxT dIdx;

    logic               start;
    logic               aAccept;
    logic               dAccept;
    logic               lastData;

    ////////////////////
    // Phase qualifiers
    ////////////////////

    // Pend is still high on the done cycle, so a finished request is not restarted
    assign start    = link.pend && !busy && !link.done;
    assign aAccept  = aPhase && hReady;
    assign dAccept  = dPhase && hReady;
    assign lastData = dAccept && (dIdx == link.len);

    ////////////////////
    // AHB outputs
    ////////////////////
    assign hTrans = aPhase ? `AXI2AHB_HTRANS_NONSEQ : `AXI2AHB_HTRANS_IDLE;

    // Word size and single transfers only
    assign hSize  = 3'b010;
    assign hBurst = 3'b000;

    // Write data follows the data-phase beat and holds with it
    assign wrBufIdx = dIdx;
    assign hWdata   = wrBufData;

    // Read beats land in the read buffer with their own error flag
    assign rdBufWe    = dAccept && !hWrite;
    assign rdBufIdx   = dIdx;
    assign rdBufEntry = '{err: hResp, data: hRdata};

    ////////////////////
    // Sequencing
    ////////////////////
    always_ff @(posedge ACLK or negedge arstN)
    begin
        if (!arstN)
        begin
            busy      <= 1'b0;
            aPhase    <= 1'b0;
            dPhase    <= 1'b0;
            link.done <= 1'b0;
        end
        else
        begin
            link.done <= lastData;
            if (start)
            begin
                busy   <= 1'b1;
                aPhase <= 1'b1;
            end
            else
            begin
                if (aAccept && aIdx == link.len)
                begin
                    aPhase <= 1'b0;
                end
                // An accepted address phase becomes the next data phase
                if (hReady)
                begin
                    dPhase <= aPhase;
                end
                if (lastData)
                begin
                    busy <= 1'b0;
                end
            end
        end
    end

    ////////////////////
    // Address and error
    ////////////////////
    always_ff @(posedge ACLK)
    begin
        if (start)
        begin
            hAddr  <= link.addr;
            hWrite <= link.isWrite;
            aIdx   <= '0;
            errAcc <= 1'b0;
        end
        else
        begin
            if (aAccept)
            begin
                aIdx  <= aIdx + 1'b1;
                dIdx  <= aIdx;
                hAddr <= hAddr + 32'd4;
            end
            // Later beats keep going after an error
            if (dAccept)
            begin
                errAcc <= errAcc | hResp;
            end
        end

        if (lastData)
        begin
            link.err <= errAcc | hResp;
        end
    end

    // NONSEQ singles only, and only while a request is pending
    hTransChk: assert property (@(posedge ACLK) disable iff (!arstN)
        hTrans == `AXI2AHB_HTRANS_IDLE
        || (hTrans == `AXI2AHB_HTRANS_NONSEQ && link.pend));

    // Stalled transfer keeps its address and its write data
    hAddrHoldChk: assert property (@(posedge ACLK) disable iff (!arstN)
        busy && !hReady |=> $stable(hAddr) && $stable(hWdata));

    // Completion only answers a request that is still pending
    doneChk: assert property (@(posedge ACLK) disable iff (!arstN)
        link.done |-> link.pend);

endmodule

`default_nettype wire

/* src/axi2ahbBridge.sv */
`timescale 1ns/1ps
`default_nettype none

// AXI3 slave to AHB-Lite master bridge, one transaction at a time
module axi2ahbBridge (
    input  wire logic              ACLK,
    input  wire logic              arstN,

    // AXI3 slave
    input  wire logic              awValid,
    input  wire axi2ahbPkg::addrT  awAddr,
    input  wire axi2ahbPkg::lenT   awLen,
    input  wire axi2ahbPkg::idT    awId,
    input  wire logic              wValid,
    input  wire axi2ahbPkg::dataT  wData,
    input  wire logic              wLast,
    input  wire logic              bReady,
    input  wire logic              arValid,
    input  wire axi2ahbPkg::addrT  arAddr,
    input  wire axi2ahbPkg::lenT   arLen,
    input  wire axi2ahbPkg::idT    arId,
    input  wire logic              rReady,
    output logic                   awReady,
    output logic                   wReady,
    output logic                   bValid,
    output logic [1:0]             bResp,
    output axi2ahbPkg::idT         bId,
    output logic                   arReady,
    output logic                   rValid,
    output axi2ahbPkg::dataT       rData,
    output logic [1:0]             rResp,
    output axi2ahbPkg::idT         rId,
    output logic                   rLast,

    // AHB-Lite master
    input  wire logic              hReady,
    input  wire logic              hResp,
    input  wire axi2ahbPkg::dataT  hRdata,
    output axi2ahbPkg::addrT       hAddr,
    output logic                   hWrite,
    output logic [1:0]             hTrans,
    output logic [2:0]             hSize,
    output logic [2:0]             hBurst,
    output axi2ahbPkg::dataT       hWdata
);

    logic                wrBufWe;
    axi2ahbPkg::bufIdxT  wrBufWrIdx;
    axi2ahbPkg::dataT    wrBufWrData;
    axi2ahbPkg::bufIdxT  wrBufRdIdx;
    axi2ahbPkg::dataT    wrBufRdData;

    logic                rdBufWe;
    axi2ahbPkg::bufIdxT  rdBufWrIdx;
    axi2ahbPkg::rdEntryT rdBufWrEntry;
    axi2ahbPkg::bufIdxT  rdBufRdIdx;
    axi2ahbPkg::rdEntryT rdBufRdEntry;

    bridgeReqIf reqIf ();

    ////////////////////
    // AXI side
    ////////////////////
    axiSlaveCtrl axiCtrl (
        .ACLK       (ACLK),
        .arstN      (arstN),
        .link       (reqIf),
        .awValid    (awValid),
        .awAddr     (awAddr),
        .awLen      (awLen),
        .awId       (awId),
        .wValid     (wValid),
        .wData      (wData),
        .wLast      (wLast),
        .bReady     (bReady),
        .arValid    (arValid),
        .arAddr     (arAddr),
        .arLen      (arLen),
        .arId       (arId),
        .rReady     (rReady),
        .rdBufEntry (rdBufRdEntry),
        .awReady    (awReady),
        .wReady     (wReady),
        .bValid     (bValid),
        .bResp      (bResp),
        .bId        (bId),
        .arReady    (arReady),
        .rValid     (rValid),
        .rData      (rData),
        .rResp      (rResp),
        .rId        (rId),
        .rLast      (rLast),
        .wrBufWe    (wrBufWe),
        .wrBufIdx   (wrBufWrIdx),
        .wrBufData  (wrBufWrData),
        .rdBufIdx   (rdBufRdIdx)
    );

    ////////////////////
    // AHB side
    ////////////////////
    ahbMasterCtrl ahbCtrl (
        .ACLK       (ACLK),
        .arstN      (arstN),
        .link       (reqIf),
        .hReady     (hReady),
        .hResp      (hResp),
        .hRdata     (hRdata),
        .wrBufData  (wrBufRdData),
        .hAddr      (hAddr),
        .hWrite     (hWrite),
        .hTrans     (hTrans),
        .hSize      (hSize),
        .hBurst     (hBurst),
        .hWdata     (hWdata),
        .wrBufIdx   (wrBufRdIdx),
        .rdBufWe    (rdBufWe),
        .rdBufIdx   (rdBufWrIdx),
        .rdBufEntry (rdBufWrEntry)
    );

    ////////////////////
    // Burst buffers
    ////////////////////
    burstBuffer #(
        .payloadT (axi2ahbPkg::dataT)
    ) wrBuf (
        .clk    (ACLK),
        .we     (wrBufWe),
        .wrIdx  (wrBufWrIdx),
        .wrData (wrBufWrData),
        .rdIdx  (wrBufRdIdx),
        .rdData (wrBufRdData)
    );

    burstBuffer #(
        .payloadT (axi2ahbPkg::rdEntryT)
    ) rdBuf (
        .clk    (ACLK),
        .we     (rdBufWe),
        .wrIdx  (rdBufWrIdx),
        .wrData (rdBufWrEntry),
        .rdIdx  (rdBufRdIdx),
        .rdData (rdBufRdEntry)
    );

endmodule

`default_nettype wire

/* verification/axi2ahbTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi2ahbConsts.svh"

module axi2ahbTb;

    localparam int NUM_ROWS = 10;
    localparam int PER_BEAT = 40;
    localparam int PER_ROW = 30;

    // Row kinds, BOTH raises AW and AR on the same edge
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ = 2'd1;
    localparam logic [1:0] OP_BOTH = 2'd2;

    typedef struct packed {
        logic [1:0]       op;
        axi2ahbPkg::addrT addr;
        axi2ahbPkg::lenT  len;
        axi2ahbPkg::idT   id;
        axi2ahbPkg::dataT base;
        logic             bp;
    } rowT;

    // Kind, address, beats minus one, ID, write data base, random B/R backpressure
    rowT stim [NUM_ROWS] = '{
        '{OP_WRITE, 32'h0000_0100, 4'd0,  4'd3,  32'h1111_0000, 1'b0},
        '{OP_READ,  32'h0000_0100, 4'd0,  4'd5,  32'h0000_0000, 1'b0},
        '{OP_WRITE, 32'h0000_0200, 4'd15, 4'd1,  32'h2222_0000, 1'b0},
        '{OP_READ,  32'h0000_0200, 4'd15, 4'd2,  32'h0000_0000, 1'b0},
        '{OP_WRITE, 32'hF000_0040, 4'd3,  4'd6,  32'h3333_0000, 1'b0},
        '{OP_READ,  32'hF000_0040, 4'd3,  4'd7,  32'h0000_0000, 1'b0},
        '{OP_WRITE, 32'h0000_0300, 4'd7,  4'd8,  32'h4444_0000, 1'b1},
        '{OP_READ,  32'h0000_0300, 4'd7,  4'd9,  32'h0000_0000, 1'b1},
        '{OP_BOTH,  32'h0000_0380, 4'd3,  4'd10, 32'h5555_0000, 1'b1},
        '{OP_READ,  32'h0000_0040, 4'd1,  4'd12, 32'h0000_0000, 1'b1}
    };

    logic                clk = 1'b0;
    logic                arstN = 1'b0;
    logic                awValid;
    axi2ahbPkg::addrT    awAddr;
    axi2ahbPkg::lenT     awLen;
    axi2ahbPkg::idT      awId;
    logic                wValid;
    axi2ahbPkg::dataT    wData;
    logic                wLast;
    logic                bReady;
    logic                arValid;
    axi2ahbPkg::addrT    arAddr;
    axi2ahbPkg::lenT     arLen;
    axi2ahbPkg::idT      arId;
    logic                rReady;
    logic                awReady;
    logic                wReady;
    logic                bValid;
    logic [1:0]          bResp;
    axi2ahbPkg::idT      bId;
    logic                arReady;
    logic                rValid;
    axi2ahbPkg::dataT    rData;
    logic [1:0]          rResp;
    axi2ahbPkg::idT      rId;
    logic                rLast;
    logic                hReady;
    logic                hResp;
    axi2ahbPkg::dataT    hRdata;
    axi2ahbPkg::addrT    hAddr;
    logic                hWrite;
    logic [1:0]          hTrans;
    logic [2:0]          hSize;
    logic [2:0]          hBurst;
    axi2ahbPkg::dataT    hWdata;

    // AHB slave state and the expected memory image
    axi2ahbPkg::dataT    ahbMem [256];
    axi2ahbPkg::dataT    shadow [256];
    logic                dataPhase;
    axi2ahbPkg::addrT    phaseAddr;
    logic                phaseWrite;
    logic                errStep;
    int                  stallLeft;
    integer              stallSeed = 7721;
    integer              readySeed = 7721;

    axi2ahbBridge dut (
        .ACLK (clk),
        .*
    );

    ////////////////////
    // Helpers
    ////////////////////
    function automatic axi2ahbPkg::dataT fillWord(input int idx);
        return 32'hA5A5_0000 ^ (32'(idx) << 2);
    endfunction

    function automatic logic inErrRegion(input axi2ahbPkg::addrT a);
        return a >= 32'hF000_0000;
    endfunction

    function automatic axi2ahbPkg::idT readIdOf(input rowT row);
        return (row.op == OP_BOTH) ? row.id + 4'd1 : row.id;
    endfunction

    function automatic logic pickReady(input logic bp);
        if (!bp)
        begin
            return 1'b1;
        end
        return (($random(readySeed) & 32'sd3) == 32'sd0);
    endfunction

    task automatic compareValues(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    ////////////////////
    // Clock and AHB slave
    ////////////////////
    initial
    begin
        forever #5 clk = ~clk;
    end

    // Responses are set up on the falling edge for the next rising edge
    initial
    begin
        hReady = 1'b1;
        hResp = 1'b0;
        hRdata = '0;
        dataPhase = 1'b0;
        for (int i = 0; i < 256; i++)
        begin
            ahbMem[i] = fillWord(i);
        end
        forever
        begin
            @(negedge clk);
            hReady = 1'b1;
            hResp = 1'b0;
            hRdata = '0;
            if (arstN && dataPhase)
            begin
                if (inErrRegion(phaseAddr))
                begin
                    // Two-cycle ERROR, hReady low on the first
                    hResp = 1'b1;
                    hReady = errStep;
                    errStep = 1'b1;
                end
                else if (stallLeft > 0)
                begin
                    hReady = 1'b0;
                    stallLeft--;
                end
                else if (phaseWrite)
                begin
                    ahbMem[phaseAddr[9:2]] = hWdata;
                end
                else
                begin
                    hRdata = ahbMem[phaseAddr[9:2]];
                end
            end
            // A ready cycle also takes whatever address phase is on the bus
            if (hReady)
            begin
                dataPhase = arstN && (hTrans == `AXI2AHB_HTRANS_NONSEQ);
                phaseAddr = hAddr;
                phaseWrite = hWrite;
                errStep = 1'b0;
                stallLeft = int'($unsigned($random(stallSeed)) % 32'd3);
                if (dataPhase)
                begin
                    compareValues("hSize", 32'(hSize), 32'd2);
                    compareValues("hBurst", 32'(hBurst), 32'd0);
                end
            end
        end
    end

    ////////////////////
    // AXI master tasks
    ////////////////////
    task automatic runWriteBurst(input rowT row);
        int               len;
        logic             taken;
        logic [1:0]       expResp;
        axi2ahbPkg::addrT beatAddr;
        len = int'(row.len);
        expResp = inErrRegion(row.addr) ? `AXI2AHB_RESP_SLVERR : `AXI2AHB_RESP_OKAY;
        #1;
        while (!awReady)
        begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awValid = 1'b0;

        // Data beats, any pending read address must stay blocked
        for (int k = 0; k <= len; k++)
        begin
            wValid = 1'b1;
            wData = row.base + 32'(k);
            wLast = (k == len);
            #1;
            compareValues("arReady", 32'(arReady), 32'd0);
            while (!wReady)
            begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        wValid = 1'b0;
        wLast = 1'b0;

        #1;
        while (!bValid)
        begin
            @(negedge clk);
            #1;
        end
        taken = 1'b0;
        while (!taken)
        begin
            @(negedge clk);
            bReady = pickReady(row.bp);
            #1;
            compareValues("bValid", 32'(bValid), 32'd1);
            compareValues("bId", 32'(bId), 32'(row.id));
            compareValues("bResp", 32'(bResp), 32'(expResp));
            compareValues("arReady", 32'(arReady), 32'd0);
            taken = bReady;
        end
        @(negedge clk);
        bReady = 1'b0;
        #1;
        compareValues("bValid", 32'(bValid), 32'd0);

        // Words land at base address plus four per beat
        for (int k = 0; k <= len; k++)
        begin
            beatAddr = row.addr + 32'(4 * k);
            if (!inErrRegion(row.addr))
            begin
                shadow[beatAddr[9:2]] = row.base + 32'(k);
                compareValues("ahbMem", ahbMem[beatAddr[9:2]], row.base + 32'(k));
            end
        end
    endtask

    task automatic runReadBurst(input rowT row);
        int               len;
        int               k;
        axi2ahbPkg::addrT beatAddr;
        axi2ahbPkg::dataT expData;
        logic [1:0]       expResp;
        len = int'(row.len);
        #1;
        while (!arReady)
        begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arValid = 1'b0;
        #1;
        while (!rValid)
        begin
            @(negedge clk);
            #1;
        end

        // Beat k only advances on a cycle with rReady high
        k = 0;
        while (k <= len)
        begin
            @(negedge clk);
            rReady = pickReady(row.bp);
            #1;
            beatAddr = row.addr + 32'(4 * k);
            expData = inErrRegion(row.addr) ? '0 : shadow[beatAddr[9:2]];
            expResp = inErrRegion(row.addr) ? `AXI2AHB_RESP_SLVERR : `AXI2AHB_RESP_OKAY;
            compareValues("rValid", 32'(rValid), 32'd1);
            compareValues("rData", rData, expData);
            compareValues("rResp", 32'(rResp), 32'(expResp));
            compareValues("rId", 32'(rId), 32'(readIdOf(row)));
            compareValues("rLast", 32'(rLast), 32'(k == len));
            if (rReady)
            begin
                k++;
            end
        end
        @(negedge clk);
        rReady = 1'b0;
        #1;
        compareValues("rValid", 32'(rValid), 32'd0);
    endtask

    task automatic applyRow(input rowT row);
        @(negedge clk);
        if (row.op != OP_READ)
        begin
            awValid = 1'b1;
            awAddr = row.addr;
            awLen = row.len;
            awId = row.id;
        end
        if (row.op != OP_WRITE)
        begin
            arValid = 1'b1;
            arAddr = row.addr;
            arLen = row.len;
            arId = readIdOf(row);
        end
        if (row.op != OP_READ)
        begin
            runWriteBurst(row);
        end
        if (row.op != OP_WRITE)
        begin
            runReadBurst(row);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial
    begin
        awValid = 1'b0;
        awAddr = '0;
        awLen = '0;
        awId = '0;
        wValid = 1'b0;
        wData = '0;
        wLast = 1'b0;
        bReady = 1'b0;
        arValid = 1'b0;
        arAddr = '0;
        arLen = '0;
        arId = '0;
        rReady = 1'b0;
        for (int i = 0; i < 256; i++)
        begin
            shadow[i] = fillWord(i);
        end

        // Ready and valid outputs stay low while in reset
        repeat (3) @(negedge clk);
        #1;
        compareValues("awReady", 32'(awReady), 32'd0);
        compareValues("wReady", 32'(wReady), 32'd0);
        compareValues("arReady", 32'(arReady), 32'd0);
        compareValues("bValid", 32'(bValid), 32'd0);
        compareValues("rValid", 32'(rValid), 32'd0);
        compareValues("hTrans", 32'(hTrans), 32'(`AXI2AHB_HTRANS_IDLE));
        @(negedge clk);
        arstN = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            applyRow(stim[r]);
        end
        $display("All tests passed");
        $finish;
    end

    // Watchdog sized from the table's beat count
    initial
    begin
        int beats;
        int limitNs;
        beats = 0;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            beats += (int'(stim[r].len) + 1) * ((stim[r].op == OP_BOTH) ? 2 : 1);
        end
        limitNs = (beats * PER_BEAT + NUM_ROWS * PER_ROW + 10) * 10;
        #(limitNs);
        $display("Timeout: stimulus table not finished after %0d ns", limitNs);
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+src
src/axi2ahbPkg.sv
src/bridgeReqIf.sv
src/burstBuffer.sv
src/axiSlaveCtrl.sv
src/ahbMasterCtrl.sv
src/axi2ahbBridge.sv
verification/axi2ahbTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = axi2ahbTb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
